// ==== source/neoBusPkg.sv ====
package neoBusPkg;

	// ==============================
	// Bus side widths
	// ==============================

	// Entry number inside one palette bank
	typedef logic [11:0] palIndex;

	// 68k data bus word
	typedef logic [15:0] busWord;

	// Selects one bit of the system latch
	typedef logic [2:0] latchSel;

	// ==============================
	// System latch select codes
	// ==============================

	// Shadow flag, halves all output channels when set
	localparam latchSel selShadow = 3'd0;

	// Palette bank, picks which half of the palette RAM is used
	localparam latchSel selPalBank = 3'd7;

	// Other codes address latch bits that are not kept here

	// ==============================
	// Write requests from the bus
	// ==============================

	// Palette write, one cycle strobe
	typedef struct packed {
		logic wr;
		palIndex addr;
		busWord data;
	} palWrite;

	// System latch write, one cycle strobe
	typedef struct packed {
		logic wr;
		latchSel sel;
		logic value;
	} latchWrite;

endpackage

// ==== source/neoVideoPkg.sv ====
package neoVideoPkg;

	// ==============================
	// Palette colour word
	// ==============================

	// Layout of one palette entry
	// Bit 15 dark
	// Bits 14..12 low bits of R, G, B
	// Bits 11..8 R nibble, 7..4 G nibble, 3..0 B nibble
	typedef logic [15:0] colorWord;

	// Bit positions inside colorWord
	localparam int darkBit = 15;
	localparam int redLowBit = 14;
	localparam int greenLowBit = 13;
	localparam int blueLowBit = 12;

	// ==============================
	// Channel types
	// ==============================

	// Nibble plus low bit plus repeated top bit
	typedef logic [5:0] channel6;

	// Final per channel output value
	typedef logic [7:0] channel8;

	// Full output pixel, red in the top byte
	typedef struct packed {
		channel8 red;
		channel8 green;
		channel8 blue;
	} rgbPixel;

	// ==============================
	// Pixel timing
	// ==============================

	// CLK_48M cycles per 6 MHz pixel
	localparam int pixelDivide = 8;

endpackage

// ==== source/clockEnables.sv ====
`timescale 1ns/1ps

module clockEnables #(
	parameter int PixelDivide = 8
) (
	input logic CLK_48M,
	input logic nRESET,
	output logic clk24Toggle,
	output logic pixelCe
);

	// Counts 24 MHz phases inside one pixel
	localparam int HalfCount = PixelDivide / 2;
	localparam int CountWidth = $clog2(PixelDivide);

	logic [CountWidth-1:0] phaseCount;

	// 24 MHz phase, flips on every master clock
	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			clk24Toggle <= 1'b0;
		end else begin
			clk24Toggle <= ~clk24Toggle;
		end
	end

	// Divider only advances on the high 24 MHz phase
	// so a pixel spans HalfCount full 24 MHz periods
	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			phaseCount <= '0;
		end else if (clk24Toggle) begin
			if (phaseCount == CountWidth'(HalfCount - 1)) begin
				phaseCount <= '0;
			end else begin
				phaseCount <= phaseCount + 1'b1;
			end
		end
	end

	// High only in the cycle where the divider wraps
	// First pulse lands PixelDivide cycles after reset release
	assign pixelCe = clk24Toggle && (phaseCount == CountWidth'(HalfCount - 1));

endmodule

// ==== source/systemLatch.sv ====
`timescale 1ns/1ps

module systemLatch (
	input logic CLK_48M,
	input logic nRESET,
	input neoBusPkg::latchWrite latchWr,
	output logic shadow,
	output logic palBank
);

	// ==============================
	// Addressable latch
	// ==============================

	// Each bus write sets or clears one selected bit
	// Only the shadow flag and the palette bank are kept
	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			shadow <= 1'b0;
			palBank <= 1'b0;
		end else if (latchWr.wr) begin
			// Decode the selector
			case (latchWr.sel)
				neoBusPkg::selShadow: begin
					shadow <= latchWr.value;
				end
				neoBusPkg::selPalBank: begin
					palBank <= latchWr.value;
				end
				default: begin
					// Vector, card and region bits live elsewhere
				end
			endcase
		end
	end

endmodule

// ==== source/paletteRam.sv ====
`timescale 1ns/1ps

module paletteRam #(
	parameter int PalIndexWidth = 12
) (
	input logic CLK_48M,
	input neoBusPkg::palWrite palWr,
	input logic palBank,
	input logic pixelCe,
	input neoBusPkg::palIndex pixelIndex,
	output neoVideoPkg::colorWord colorOut
);

	// Two banks, bank bit on top of the entry number
	localparam int AddrWidth = PalIndexWidth + 1;
	localparam int Depth = 2 ** AddrWidth;

	neoVideoPkg::colorWord palMem [Depth];

	logic [AddrWidth-1:0] writeAddr;
	logic [AddrWidth-1:0] readAddr;

	// ==============================
	// Address forming
	// ==============================

	// Bus writes land in the bank that is latched right now
	assign writeAddr = {palBank, palWr.addr[PalIndexWidth-1:0]};

	// Video side uses the same bank bit
	assign readAddr = {palBank, pixelIndex[PalIndexWidth-1:0]};

	// ==============================
	// Memory ports
	// ==============================

	// Bus write port
	always_ff @(posedge CLK_48M) begin
		if (palWr.wr) begin
			palMem[writeAddr] <= neoVideoPkg::colorWord'(palWr.data);
		end
	end

	// Pixel read port, loads once per pixel
	// A write on the same edge is seen by the next lookup
	always_ff @(posedge CLK_48M) begin
		if (pixelCe) begin
			colorOut <= palMem[readAddr];
		end
	end

endmodule

// ==== source/colorDecode.sv ====
`timescale 1ns/1ps

module colorDecode (
	input logic CLK_48M,
	input logic nRESET,
	input logic pixelCe,
	input neoVideoPkg::colorWord colorIn,
	input logic shadow,
	output neoVideoPkg::rgbPixel pixel
);

	logic dark;
	neoVideoPkg::channel8 redFull;
	neoVideoPkg::channel8 greenFull;
	neoVideoPkg::channel8 blueFull;
	neoVideoPkg::rgbPixel nextPixel;

	// ==============================
	// Per channel expansion
	// ==============================

	// Nibble, then low bit, then nibble top bit
	// Dark takes one step off, clamped at zero
	// 6 bit level is widened by repeating its bits 4 and 3
	function automatic neoVideoPkg::channel8 expandChannel(
		input logic [3:0] nibble,
		input logic lowBit,
		input logic darkIn
	);
		logic [6:0] wide;
		neoVideoPkg::channel6 level;
		wide = {1'b0, nibble, lowBit, nibble[3]} - {6'd0, darkIn};
		// Borrow out of bit 6 means the level went below zero
		level = wide[6] ? '0 : wide[5:0];
		return {level, level[4:3]};
	endfunction

	// Halves one channel when shadow is on
	function automatic neoVideoPkg::channel8 shadeChannel(
		input neoVideoPkg::channel8 value,
		input logic shadowIn
	);
		return shadowIn ? {1'b0, value[7:1]} : value;
	endfunction

	assign dark = colorIn[neoVideoPkg::darkBit];

	assign redFull = expandChannel(colorIn[11:8], colorIn[neoVideoPkg::redLowBit], dark);
	assign greenFull = expandChannel(colorIn[7:4], colorIn[neoVideoPkg::greenLowBit], dark);
	assign blueFull = expandChannel(colorIn[3:0], colorIn[neoVideoPkg::blueLowBit], dark);

	// Shadow applied last, after the dark step
	assign nextPixel.red = shadeChannel(redFull, shadow);
	assign nextPixel.green = shadeChannel(greenFull, shadow);
	assign nextPixel.blue = shadeChannel(blueFull, shadow);

	// ==============================
	// Output register
	// ==============================

	// One load per pixel, one pixel behind the palette lookup
	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			pixel <= '0;
		end else if (pixelCe) begin
			pixel <= nextPixel;
		end
	end

endmodule

// ==== source/neoVideoOut.sv ====
`timescale 1ns/1ps

module neoVideoOut #(
	parameter int PalIndexWidth = 12,
	parameter int PixelDivide = neoVideoPkg::pixelDivide
) (
	input logic CLK_48M,
	input logic nRESET,
	input neoBusPkg::palWrite palWr,
	input neoBusPkg::latchWrite latchWr,
	input neoBusPkg::palIndex pixelIndex,
	output neoVideoPkg::rgbPixel pixel,
	output logic pixelCe
);

	// Latch outputs
	logic shadow;
	logic palBank;

	// Palette word on its way to the decoder
	neoVideoPkg::colorWord colorWord;

	// ==============================
	// Pixel timing
	// ==============================

	// 24 MHz phase stays inside the divider
	clockEnables #(
		.PixelDivide(PixelDivide)
	) clockEnables_inst (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.clk24Toggle(),
		.pixelCe(pixelCe)
	);

	// Shadow flag and palette bank
	systemLatch systemLatch_inst (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.latchWr(latchWr),
		.shadow(shadow),
		.palBank(palBank)
	);

	// ==============================
	// Colour path
	// ==============================

	// Lookup, first pixel stage
	paletteRam #(
		.PalIndexWidth(PalIndexWidth)
	) paletteRam_inst (
		.CLK_48M(CLK_48M),
		.palWr(palWr),
		.palBank(palBank),
		.pixelCe(pixelCe),
		.pixelIndex(pixelIndex),
		.colorOut(colorWord)
	);

	// Expansion and shadow, second pixel stage
	colorDecode colorDecode_inst (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.pixelCe(pixelCe),
		.colorIn(colorWord),
		.shadow(shadow),
		.pixel(pixel)
	);

endmodule

// ==== verif/neoVideoOut_chk.sv ====
`timescale 1ns/1ps

module neoVideoOut_chk (
	input logic CLK_48M,
	input logic nRESET,
	input logic pixelCe,
	input neoVideoPkg::rgbPixel pixel
);

	// Master clock cycles between two pixel pulses
	localparam int PixelDivide = neoVideoPkg::pixelDivide;

	// ==============================
	// Pixel enable shape
	// ==============================

	// Strobe lasts a single master cycle
	singlePulse: assert property (@(posedge CLK_48M) disable iff (!nRESET)
		pixelCe |=> !pixelCe)
		else $error("pixelCe stayed high for two cycles in a row");

	// Next pulse arrives exactly one pixel later
	pulseRecurs: assert property (@(posedge CLK_48M) disable iff (!nRESET)
		pixelCe |-> ##PixelDivide pixelCe)
		else $error("pixelCe did not recur after one pixel period");

	// ==============================
	// Output timing
	// ==============================

	// Output register only loads on the pixel tick
	pixelOnTick: assert property (@(posedge CLK_48M) disable iff (!nRESET)
		!$stable(pixel) |-> $past(pixelCe))
		else $error("pixel changed away from a pixelCe tick");

	// Reset clears RGB
	pixelInReset: assert property (@(posedge CLK_48M)
		!nRESET |-> (pixel == '0))
		else $error("pixel not zero while nRESET is low");

endmodule

// Attach to every copy of the top level
bind neoVideoOut neoVideoOut_chk neoVideoOut_chk_inst (
	.CLK_48M(CLK_48M),
	.nRESET(nRESET),
	.pixelCe(pixelCe),
	.pixel(pixel)
);

// ==== verif/neoVideoOutTb.sv ====
`timescale 1ns/1ps

module neoVideoOutTb;

	// ==============================
	// Limits and table layout
	// ==============================

	// Longest wait for any pixel pulse, in master cycles
	localparam int waitLimit = 4 * neoVideoPkg::pixelDivide;
	localparam int randomCount = 20;

	typedef enum logic [1:0] {
		opPalWrite,
		opLatchWrite,
		opLookup
	} opKind;

	// One table step, unused fields stay zero
	typedef struct packed {
		opKind op;
		neoBusPkg::palIndex index;
		neoBusPkg::busWord data;
		neoBusPkg::latchSel sel;
		logic value;
		neoVideoPkg::rgbPixel expected;
	} tableRow;

	logic CLK_48M;
	logic nRESET;
	neoBusPkg::palWrite palWr;
	neoBusPkg::latchWrite latchWr;
	neoBusPkg::palIndex pixelIndex;
	neoVideoPkg::rgbPixel pixel;
	logic pixelCe;

	tableRow stimTable [$];
	string rowName [$];
	neoBusPkg::busWord randomWords [randomCount];
	int rateCount;

	neoVideoOut #(
		.PalIndexWidth(12),
		.PixelDivide(neoVideoPkg::pixelDivide)
	) neoVideoOut_inst (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.palWr(palWr),
		.latchWr(latchWr),
		.pixelIndex(pixelIndex),
		.pixel(pixel),
		.pixelCe(pixelCe)
	);

	// 25 MHz stand in for the 48 MHz master clock
	initial begin
		CLK_48M = 1'b0;
		forever #20 CLK_48M = ~CLK_48M;
	end

	// ==============================
	// Reporting
	// ==============================

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			reportFailure($sformatf("Fail %s expected %h actual %h", testName, expected, actual));
		end
	endtask

	// ==============================
	// Bus and video side drivers
	// ==============================

	// Returns on a falling edge where pixelCe is high, never the current one
	task automatic waitPixelCe(input string where);
		int waited;
		waited = 0;
		@(negedge CLK_48M);
		while (!pixelCe && waited < waitLimit) begin
			@(negedge CLK_48M);
			waited++;
		end
		if (!pixelCe) begin
			reportFailure($sformatf("Timed out waiting for pixelCe during %s", where));
		end
	endtask

	// One cycle strobe, called on a falling edge
	task automatic writePalette(input neoBusPkg::palIndex addr, input neoBusPkg::busWord data);
		palWr.wr = 1'b1;
		palWr.addr = addr;
		palWr.data = data;
		@(negedge CLK_48M);
		palWr.wr = 1'b0;
	endtask

	task automatic writeLatch(input neoBusPkg::latchSel sel, input logic value);
		latchWr.wr = 1'b1;
		latchWr.sel = sel;
		latchWr.value = value;
		@(negedge CLK_48M);
		latchWr.wr = 1'b0;
	endtask

	// Index goes in before tick N, result is read after tick N+1
	task automatic lookupAndCheck(input neoBusPkg::palIndex index,
			input neoVideoPkg::rgbPixel expected, input string name);
		waitPixelCe($sformatf("%s sample", name));
		pixelIndex = index;
		waitPixelCe($sformatf("%s lookup", name));
		waitPixelCe($sformatf("%s output", name));
		checkValue(name, 32'(expected), 32'(pixel));
	endtask

	// ==============================
	// Reference colour model
	// ==============================

	// Integer form of the channel rule
	function automatic int modelChannel(input int nibble, input int lowBit, input int darkOn,
			input int shadeOn);
		int level;
		int full;
		level = nibble * 4 + lowBit * 2 + nibble / 8 - darkOn;
		if (level < 0) begin
			level = 0;
		end
		// Append level bits 4 and 3 below the 6 bit value
		full = level * 4 + (level / 8) % 4;
		if (shadeOn != 0) begin
			full = full / 2;
		end
		return full;
	endfunction

	function automatic neoVideoPkg::rgbPixel modelColor(input neoBusPkg::busWord word,
			input logic shadeOn);
		neoVideoPkg::rgbPixel result;
		int darkOn;
		int shade;
		darkOn = int'(word[15]);
		shade = int'(shadeOn);
		result.red = 8'(modelChannel(int'(word[11:8]), int'(word[14]), darkOn, shade));
		result.green = 8'(modelChannel(int'(word[7:4]), int'(word[13]), darkOn, shade));
		result.blue = 8'(modelChannel(int'(word[3:0]), int'(word[12]), darkOn, shade));
		return result;
	endfunction

	// ==============================
	// Stimulus table
	// ==============================

	function automatic tableRow paletteRow(input neoBusPkg::palIndex index,
			input neoBusPkg::busWord data);
		tableRow row;
		row = '0;
		row.op = opPalWrite;
		row.index = index;
		row.data = data;
		return row;
	endfunction

	function automatic tableRow latchRow(input neoBusPkg::latchSel sel, input logic value);
		tableRow row;
		row = '0;
		row.op = opLatchWrite;
		row.sel = sel;
		row.value = value;
		return row;
	endfunction

	function automatic tableRow lookupRow(input neoBusPkg::palIndex index,
			input neoVideoPkg::rgbPixel expected);
		tableRow row;
		row = '0;
		row.op = opLookup;
		row.index = index;
		row.expected = expected;
		return row;
	endfunction

	task automatic addRow(input tableRow row, input string name);
		stimTable.push_back(row);
		rowName.push_back(name);
	endtask

	// Expected RGB worked out by hand from the colour rule
	task automatic buildTable();
		// Plain and dark words, bank 0, no shadow
		addRow(paletteRow(12'h010, 16'h4F00), "write red");
		addRow(paletteRow(12'h011, 16'h7FFF), "write white");
		addRow(paletteRow(12'h012, 16'h2842), "write mixed");
		addRow(paletteRow(12'h013, 16'h8F00), "write dark red");
		addRow(paletteRow(12'h014, 16'hFFFF), "write dark white");
		addRow(paletteRow(12'h016, 16'h8000), "write dark black");
		addRow(lookupRow(12'h010, 24'hFF0000), "pure red");
		addRow(lookupRow(12'h011, 24'hFFFFFF), "white");
		addRow(lookupRow(12'h012, 24'h844A21), "mixed low bits");
		addRow(lookupRow(12'h013, 24'hF30000), "dark red with clamp");
		addRow(lookupRow(12'h014, 24'hFBFBFB), "dark white");
		addRow(lookupRow(12'h016, 24'h000000), "dark black clamp");
		// Shadow halves, clearing restores
		addRow(latchRow(neoBusPkg::selShadow, 1'b1), "shadow on");
		addRow(lookupRow(12'h012, 24'h422510), "shadow mixed");
		addRow(lookupRow(12'h011, 24'h7F7F7F), "shadow white");
		addRow(latchRow(neoBusPkg::selShadow, 1'b0), "shadow off");
		addRow(lookupRow(12'h012, 24'h844A21), "shadow cleared");
		// Same index, one word per bank
		addRow(paletteRow(12'h123, 16'h4F00), "bank 0 write");
		addRow(latchRow(neoBusPkg::selPalBank, 1'b1), "select bank 1");
		addRow(paletteRow(12'h123, 16'h20F0), "bank 1 write");
		addRow(lookupRow(12'h123, 24'h00FF00), "bank 1 entry");
		addRow(latchRow(neoBusPkg::selPalBank, 1'b0), "select bank 0");
		addRow(lookupRow(12'h123, 24'hFF0000), "bank 0 entry");
		// Selectors 3 and 5 hit no kept bit
		addRow(latchRow(3'd3, 1'b1), "ignored set");
		addRow(lookupRow(12'h123, 24'hFF0000), "ignored selector set");
		addRow(latchRow(neoBusPkg::selPalBank, 1'b1), "back to bank 1");
		addRow(latchRow(3'd5, 1'b0), "ignored clear");
		addRow(lookupRow(12'h123, 24'h00FF00), "ignored selector clear");
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		palWr = '0;
		latchWr = '0;
		pixelIndex = '0;
		nRESET = 1'b0;
		void'($urandom(2647));
		buildTable();

		// Three cycles of reset, released on a falling edge
		repeat (3) @(posedge CLK_48M);
		@(negedge CLK_48M);
		nRESET = 1'b1;
		@(negedge CLK_48M);
		checkValue("reset output", 32'h0, 32'(pixel));

		for (int i = 0; i < stimTable.size(); i++) begin
			case (stimTable[i].op)
				opPalWrite: begin
					writePalette(stimTable[i].index, stimTable[i].data);
				end
				opLatchWrite: begin
					writeLatch(stimTable[i].sel, stimTable[i].value);
				end
				default: begin
					lookupAndCheck(stimTable[i].index, stimTable[i].expected, rowName[i]);
				end
			endcase
		end

		// Random words in bank 1, shadow turned on for the second half
		for (int i = 0; i < randomCount; i++) begin
			randomWords[i] = 16'($urandom());
			writePalette(12'(512 + i), randomWords[i]);
		end
		for (int i = 0; i < randomCount; i++) begin
			if (i == randomCount / 2) begin
				writeLatch(neoBusPkg::selShadow, 1'b1);
			end
			lookupAndCheck(12'(512 + i), modelColor(randomWords[i], i >= randomCount / 2),
				$sformatf("random word %h", randomWords[i]));
		end

		// Master cycles from one pixel pulse to the next
		waitPixelCe("rate start");
		rateCount = 0;
		do begin
			@(negedge CLK_48M);
			rateCount++;
		end while (!pixelCe && rateCount < waitLimit);
		checkValue("pixel rate", 32'(neoVideoPkg::pixelDivide), 32'(rateCount));

		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== list.f ====
source/neoBusPkg.sv
source/neoVideoPkg.sv
source/clockEnables.sv
source/systemLatch.sv
source/paletteRam.sv
source/colorDecode.sv
source/neoVideoOut.sv
verif/neoVideoOut_chk.sv
verif/neoVideoOutTb.sv

// ==== run.sh ====
#!/bin/sh
# Build DUT and testbench with Verilator, run, then scan the log

verilator --binary --timing --assert --top-module neoVideoOutTb -Mdir obj_dir -f list.f \
	> build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/VneoVideoOutTb > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0
